// File: hdl/nic_cfg.svh
`ifndef NIC_CFG_SVH
`define NIC_CFG_SVH

// Width of one flit payload in bits
`define FLIT_WIDTH 32

// Data flits that follow each request header
`define DATA_FLITS 4

// Packet credits held by the output side after reset
// One credit covers one whole response packet
`define OUTPUT_CREDITS 2

// Identifier of this node, used as src in every response header
`define NODE_ID 8'h2A

`endif

// File: hdl/noc_flit_pkg.sv
`include "nic_cfg.svh"

package noc_flit_pkg;

	// Raw payload carried by every flit
	typedef logic [`FLIT_WIDTH-1:0] flit_payload_t;

	// Node address on the network
	typedef logic [7:0] node_id_t;

	// Opcode as it sits in the header, decoded by the engine
	typedef logic [1:0] opcode_field_t;

	// One flit on the link, head bit marks the first flit of a packet
	typedef struct packed {
		logic          head;
		flit_payload_t payload;
	} flit_t;

	// Layout of a header payload, dst in the top byte
	typedef struct packed {
		node_id_t                dst;
		node_id_t                src;
		opcode_field_t           opcode;
		logic [`FLIT_WIDTH-19:0] reserved;
	} header_t;

	// Complete request as handed to the engine
	// data[0] is the first data flit after the header
	typedef struct packed {
		header_t                         header;
		flit_payload_t [`DATA_FLITS-1:0] data;
	} packet_t;

endpackage

// File: hdl/test_engine_pkg.sv
`include "nic_cfg.svh"

package test_engine_pkg;
	import noc_flit_pkg::*;

	// Reduction selected by the request header
	typedef enum logic [1:0] {
		OP_SUM = 2'd0,
		OP_XOR = 2'd1,
		OP_MAX = 2'd2,
		OP_MIN = 2'd3
	} op_t;

	// Reduced value, same width as a flit payload
	typedef logic [`FLIT_WIDTH-1:0] result_t;

	// Result handed from the engine to the output side
	typedef struct packed {
		node_id_t reply_dst;
		result_t  value;
	} response_t;

	// Data flit index inside the engine
	typedef logic [$clog2(`DATA_FLITS+1)-1:0] flit_idx_t;

	// Output credit count, 0 up to OUTPUT_CREDITS
	typedef logic [$clog2(`OUTPUT_CREDITS+1)-1:0] credit_cnt_t;

	// FSM encodings
	typedef enum logic [1:0] {IDLE, CAPTURE, WAIT} icu_state_t;
	typedef enum logic [1:0] {PE_IDLE, PE_RUN, PE_DONE} pe_state_t;
	typedef enum logic [1:0] {OB_EMPTY, OB_HEAD, OB_BODY} ob_state_t;

endpackage

// File: hdl/nic_input_control_unit.sv
`timescale 1ns/10ps
`include "nic_cfg.svh"

module nic_input_control_unit
	import test_engine_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 header_field,
	input  logic                 busy_engine,
	input  logic                 zero_credits,
	output logic                 transfer2pe_strobe,
	output logic                 write_strobe,
	output logic [`DATA_FLITS:0] register_enable
);

	// Enable pattern for slot 0, where the header lands
	localparam logic [`DATA_FLITS:0] SLOT_HEADER = {{`DATA_FLITS{1'b0}}, 1'b1};

	icu_state_t           state_reg;
	icu_state_t           state_next;
	logic [`DATA_FLITS:0] enable_next;
	logic                 pe_free;
	logic                 last_slot;

	// Engine idle and a response slot guaranteed on the output side
	assign pe_free = !busy_engine && !zero_credits;

	// Final data flit is on the link in this cycle
	assign last_slot = (state_reg == CAPTURE) && register_enable[`DATA_FLITS];

	always_ff @(posedge clk)
	begin
		if (reset)
			state_reg <= IDLE;
		else
			state_reg <= state_next;
	end

	// Next state
	always_comb
	begin
		state_next = state_reg;
		case (state_reg)
			IDLE:
				if (header_field)
					state_next = CAPTURE;
			CAPTURE:
				// Hand over right away if possible, else park the packet
				if (last_slot)
					state_next = pe_free ? IDLE : WAIT;
			WAIT:
				if (pe_free)
					state_next = IDLE;
			default:
				state_next = IDLE;
		endcase
	end

	// Hand over on the last flit or later out of WAIT
	assign transfer2pe_strobe = (last_slot || (state_reg == WAIT)) && pe_free;

	// Header in IDLE, then one flit per cycle since flits come back to back
	assign write_strobe = ((state_reg == IDLE) && header_field) || (state_reg == CAPTURE);

	// One-hot sequencer
	// Rotates per written flit, wraps to slot 0 after the last data flit
	always_comb
	begin
		if (write_strobe)
			enable_next = {register_enable[`DATA_FLITS-1:0], register_enable[`DATA_FLITS]};
		else if (state_next == IDLE)
			enable_next = SLOT_HEADER;
		else
			enable_next = register_enable;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			register_enable <= SLOT_HEADER;
		else
			register_enable <= enable_next;
	end

	// Exactly one bank slot selected in every cycle
	assert property (@(posedge clk) disable iff (reset) $onehot(register_enable));

endmodule

// File: hdl/nic_input_block.sv
`timescale 1ns/10ps
`include "nic_cfg.svh"

module nic_input_block
	import noc_flit_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    in_valid,
	input  flit_t   in_flit,
	output logic    in_credit,
	input  logic    busy_engine,
	input  logic    zero_credits,
	output packet_t packet,
	output logic    transfer2pe_strobe
);

	// Flit bank, slot 0 is the header
	flit_payload_t        bank [`DATA_FLITS+1];
	// Bank as seen this cycle, with the flit being written passed through
	flit_payload_t        slot_view [`DATA_FLITS+1];
	logic                 header_field;
	logic                 write_strobe;
	logic [`DATA_FLITS:0] register_enable;

	// Start of packet
	assign header_field = in_valid && in_flit.head;

	nic_input_control_unit u_control (
		.clk                (clk),
		.reset              (reset),
		.header_field       (header_field),
		.busy_engine        (busy_engine),
		.zero_credits       (zero_credits),
		.transfer2pe_strobe (transfer2pe_strobe),
		.write_strobe       (write_strobe),
		.register_enable    (register_enable)
	);

	// Each enable bit owns one slot
	always_ff @(posedge clk)
	begin
		for (int i = 0; i <= `DATA_FLITS; i++)
			if (write_strobe && register_enable[i])
				bank[i] <= in_flit.payload;
	end

	// Last data flit is still on the link when the strobe fires on it
	always_comb
	begin
		for (int i = 0; i <= `DATA_FLITS; i++)
			slot_view[i] = (write_strobe && register_enable[i]) ? in_flit.payload : bank[i];
	end

	always_comb
	begin
		packet.header = header_t'(slot_view[0]);
		for (int i = 0; i < `DATA_FLITS; i++)
			packet.data[i] = slot_view[i+1];
	end

	// Buffer freed as soon as the engine takes the packet
	assign in_credit = transfer2pe_strobe;

	// A data flit must always fall into a running capture,
	// never into an idle or parked control unit
	assert property (@(posedge clk) disable iff (reset)
		(in_valid && !in_flit.head) |-> write_strobe);

endmodule

// File: hdl/test_engine_pe.sv
`timescale 1ns/10ps
`include "nic_cfg.svh"

module test_engine_pe
	import noc_flit_pkg::*;
	import test_engine_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      start,
	input  packet_t   packet,
	output logic      busy_engine,
	output logic      res_valid,
	output response_t res_data,
	input  logic      res_ready
);

	pe_state_t                       state_reg;
	flit_idx_t                       idx_reg;
	op_t                             op_reg;
	node_id_t                        src_reg;
	flit_payload_t [`DATA_FLITS-1:0] data_reg;
	result_t                         acc_reg;
	result_t                         acc_next;
	flit_payload_t                   operand;
	logic                            last_flit;

	// Flit reduced in this cycle
	assign operand   = data_reg[idx_reg];
	assign last_flit = (idx_reg == flit_idx_t'(`DATA_FLITS-1));

	// One reduction step, max and min compare unsigned
	always_comb
	begin
		case (op_reg)
			OP_SUM:  acc_next = acc_reg + operand;
			OP_XOR:  acc_next = acc_reg ^ operand;
			OP_MAX:  acc_next = (operand > acc_reg) ? operand : acc_reg;
			OP_MIN:  acc_next = (operand < acc_reg) ? operand : acc_reg;
			default: acc_next = acc_reg;
		endcase
		// Seed from the first flit
		if (idx_reg == '0)
			acc_next = operand;
	end

	// Control FSM, DATA_FLITS cycles in PE_RUN
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state_reg <= PE_IDLE;
			idx_reg   <= '0;
		end
		else
		begin
			case (state_reg)
				PE_IDLE:
					if (start)
					begin
						state_reg <= PE_RUN;
						idx_reg   <= '0;
					end
				PE_RUN:
				begin
					idx_reg <= idx_reg + 1'b1;
					if (last_flit)
						state_reg <= PE_DONE;
				end
				PE_DONE:
					// Hold the result until the output side takes it
					if (res_ready)
						state_reg <= PE_IDLE;
				default:
					state_reg <= PE_IDLE;
			endcase
		end
	end

	// Request latch and accumulator
	always_ff @(posedge clk)
	begin
		if ((state_reg == PE_IDLE) && start)
		begin
			data_reg <= packet.data;
			op_reg   <= op_t'(packet.header.opcode);
			src_reg  <= packet.header.src;
		end
		if (state_reg == PE_RUN)
			acc_reg <= acc_next;
	end

	assign busy_engine        = (state_reg != PE_IDLE);
	assign res_valid          = (state_reg == PE_DONE);
	// Reply goes back to the requester
	assign res_data.reply_dst = src_reg;
	assign res_data.value     = acc_reg;

	// Input side only starts the engine when it is free
	assert property (@(posedge clk) disable iff (reset) start |-> !busy_engine);

endmodule

// File: hdl/nic_output_block.sv
`timescale 1ns/10ps
`include "nic_cfg.svh"

module nic_output_block
	import noc_flit_pkg::*;
	import test_engine_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      res_valid,
	input  response_t res_data,
	output logic      res_ready,
	output logic      out_valid,
	output flit_t     out_flit,
	input  logic      out_credit_in,
	output logic      zero_credits
);

	ob_state_t   state_reg;
	credit_cnt_t credit_reg;
	response_t   buf_reg;
	header_t     reply_header;
	logic        header_sent;

	// Single entry, so only accept when nothing is pending
	assign res_ready = (state_reg == OB_EMPTY);

	// Header leaves only with a credit in hand
	assign header_sent = (state_reg == OB_HEAD) && (credit_reg != '0);

	// Tells the input side not to release another packet
	assign zero_credits = (credit_reg == '0) || (state_reg != OB_EMPTY);

	// Response header, opcode and reserved bits zero
	always_comb
	begin
		reply_header     = '0;
		reply_header.dst = buf_reg.reply_dst;
		reply_header.src = node_id_t'(`NODE_ID);
	end

	// Two beats, head flit then result flit
	always_comb
	begin
		out_valid        = header_sent || (state_reg == OB_BODY);
		out_flit.head    = header_sent;
		out_flit.payload = (state_reg == OB_BODY) ? buf_reg.value : flit_payload_t'(reply_header);
	end

	// Sender FSM
	always_ff @(posedge clk)
	begin
		if (reset)
			state_reg <= OB_EMPTY;
		else
		begin
			case (state_reg)
				OB_EMPTY:
					if (res_valid)
						state_reg <= OB_HEAD;
				OB_HEAD:
					// Stall here while the network holds back credits
					if (header_sent)
						state_reg <= OB_BODY;
				OB_BODY:
					state_reg <= OB_EMPTY;
				default:
					state_reg <= OB_EMPTY;
			endcase
		end
	end

	// Response buffer
	always_ff @(posedge clk)
	begin
		if (res_valid && res_ready)
			buf_reg <= res_data;
	end

	// Packet credits, return and use in one cycle cancel out
	always_ff @(posedge clk)
	begin
		if (reset)
			credit_reg <= credit_cnt_t'(`OUTPUT_CREDITS);
		else if (out_credit_in && !header_sent)
		begin
			if (credit_reg != credit_cnt_t'(`OUTPUT_CREDITS))
				credit_reg <= credit_reg + 1'b1;
		end
		else if (header_sent && !out_credit_in)
			credit_reg <= credit_reg - 1'b1;
	end

	// Network never returns more credits than packets it received,
	// so the count never goes above OUTPUT_CREDITS
	assert property (@(posedge clk) disable iff (reset)
		out_credit_in |-> (header_sent || (credit_reg < credit_cnt_t'(`OUTPUT_CREDITS))));

endmodule

// File: hdl/test_engine_node.sv
`timescale 1ns/10ps

module test_engine_node
	import noc_flit_pkg::*;
	import test_engine_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  in_valid,
	input  flit_t in_flit,
	output logic  in_credit,
	output logic  out_valid,
	output flit_t out_flit,
	input  logic  out_credit_in
);

	// Input side to engine
	packet_t   packet;
	logic      transfer2pe_strobe;
	logic      busy_engine;
	// Output side back to input side
	logic      zero_credits;
	// Engine to output side
	logic      res_valid;
	logic      res_ready;
	response_t res_data;

	nic_input_block u_input (
		.clk                (clk),
		.reset              (reset),
		.in_valid           (in_valid),
		.in_flit            (in_flit),
		.in_credit          (in_credit),
		.busy_engine        (busy_engine),
		.zero_credits       (zero_credits),
		.packet             (packet),
		.transfer2pe_strobe (transfer2pe_strobe)
	);

	test_engine_pe u_engine (
		.clk         (clk),
		.reset       (reset),
		.start       (transfer2pe_strobe),
		.packet      (packet),
		.busy_engine (busy_engine),
		.res_valid   (res_valid),
		.res_data    (res_data),
		.res_ready   (res_ready)
	);

	nic_output_block u_output (
		.clk           (clk),
		.reset         (reset),
		.res_valid     (res_valid),
		.res_data      (res_data),
		.res_ready     (res_ready),
		.out_valid     (out_valid),
		.out_flit      (out_flit),
		.out_credit_in (out_credit_in),
		.zero_credits  (zero_credits)
	);

endmodule

// File: tests/test_engine_node_tb.sv
`timescale 1ns/10ps
`include "nic_cfg.svh"

module test_engine_node_tb
	import noc_flit_pkg::*;
	import test_engine_pkg::*;
;

	localparam int RANDOM_PACKETS = 40;
	localparam int HOLD_CYCLES    = 50;
	localparam int NUM_PACKETS    = 4 + RANDOM_PACKETS + `OUTPUT_CREDITS + 1;
	// Per packet budget covers capture, reduction and the two-beat reply
	localparam int TIMEOUT_CYCLES = NUM_PACKETS * (2 * `DATA_FLITS + 8) + HOLD_CYCLES + 300;

	logic  clk = 1'b0;
	logic  reset;
	logic  in_valid;
	flit_t in_flit;
	logic  in_credit;
	logic  out_valid;
	flit_t out_flit;
	logic  out_credit_in;

	// Expected {reply header payload, result value} with the oldest first
	logic [2*`FLIT_WIDTH-1:0] exp_q [$];
	logic [2*`FLIT_WIDTH-1:0] exp_head;

	logic [31:0] stim_state  = 32'h34f;
	logic [31:0] delay_state = 32'h34f;
	int          packets_sent     = 0;
	int          credit_pulses    = 0;
	int          heads_seen       = 0;
	int          responses_seen   = 0;
	int          credits_returned = 0;
	int          cycle_count      = 0;
	logic        hold_credits     = 1'b0;
	logic        in_body          = 1'b0;

	test_engine_node dut (
		.clk           (clk),
		.reset         (reset),
		.in_valid      (in_valid),
		.in_flit       (in_flit),
		.in_credit     (in_credit),
		.out_valid     (out_valid),
		.out_flit      (out_flit),
		.out_credit_in (out_credit_in)
	);

	always #10 clk = ~clk;

	// Galois LFSR shifting right
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] random_bits(inout logic [31:0] state, input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			state = lfsr_next(state);
			r = {r[30:0], state[0]};
		end
		return r;
	endfunction

	// Reference model
	// Reply goes back to the requester and carries the reduction over all data flits
	function automatic logic [2*`FLIT_WIDTH-1:0] ref_response(input op_t op,
		input node_id_t src, input flit_payload_t [`DATA_FLITS-1:0] data);
		header_t reply;
		result_t acc;
		reply     = '0;
		reply.dst = src;
		reply.src = `NODE_ID;
		acc       = data[0];
		for (int i = 1; i < `DATA_FLITS; i++)
		begin
			case (op)
				OP_SUM:
					acc = acc + data[i];
				OP_XOR:
					acc = acc ^ data[i];
				OP_MAX:
					if (data[i] > acc)
						acc = data[i];
				default:
					if (data[i] < acc)
						acc = data[i];
			endcase
		end
		return {flit_payload_t'(reply), acc};
	endfunction

	// Directed operands with a wrapping sum and repeated extremes
	function automatic flit_payload_t [`DATA_FLITS-1:0] directed_data(input op_t op);
		flit_payload_t [`DATA_FLITS-1:0] d;
		for (int i = 0; i < `DATA_FLITS; i++)
		begin
			case (op)
				OP_SUM: d[i] = 32'hC000_0000 + i;
				OP_XOR: d[i] = 32'h1357_9BDF ^ (i * 32'h0101_0101);
				OP_MAX: d[i] = (i == 0) ? 32'h0000_0005 : 32'h9000_0000;
				default: d[i] = (i == 0) ? 32'hFFFF_FFFF : 32'h0000_0010;
			endcase
		end
		return d;
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected)
		begin
			$display("error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
			abort_run("value mismatch");
		end
	endtask

	// Waits for the single upstream credit and then sends header and data back to back
	task automatic send_packet(input op_t op, input node_id_t src,
		input flit_payload_t [`DATA_FLITS-1:0] data);
		header_t hdr;
		@(posedge clk);
		// Credit pulse in the cycle just ended counts already
		while (1 + credit_pulses + int'(in_credit) - packets_sent <= 0)
			@(posedge clk);
		hdr        = '0;
		hdr.dst    = `NODE_ID;
		hdr.src    = src;
		hdr.opcode = op;
		packets_sent++;
		exp_q.push_back(ref_response(op, src, data));
		in_valid <= 1'b1;
		in_flit  <= {1'b1, flit_payload_t'(hdr)};
		for (int i = 0; i < `DATA_FLITS; i++)
		begin
			@(posedge clk);
			in_flit <= {1'b0, data[i]};
		end
		@(posedge clk);
		in_valid <= 1'b0;
		in_flit  <= '0;
	endtask

	task automatic send_random_packet();
		logic [31:0] r;
		node_id_t src;
		flit_payload_t [`DATA_FLITS-1:0] data;
		r   = random_bits(stim_state, 2);
		src = node_id_t'(random_bits(stim_state, 8));
		for (int i = 0; i < `DATA_FLITS; i++)
			data[i] = random_bits(stim_state, 32);
		send_packet(op_t'(r[1:0]), src, data);
	endtask

	// All responses seen and all network credits handed back
	task automatic wait_drain();
		while (exp_q.size() != 0 || credits_returned != heads_seen)
			@(posedge clk);
		repeat (3) @(posedge clk);
		check_value("in_credit pulse count", credit_pulses, packets_sent);
	endtask

	// Upstream credits returned by the DUT
	always @(posedge clk)
	begin
		if (reset)
			credit_pulses <= 0;
		else if (in_credit)
			credit_pulses <= credit_pulses + 1;
	end

	// Response monitor expecting a head flit and then the result flit in the next cycle
	always @(posedge clk)
	begin
		if (!reset)
		begin
			if (in_body)
			begin
				if (!out_valid)
					abort_run("result flit missing right after a response header");
				exp_head = exp_q.pop_front();
				check_value("out_flit.head", out_flit.head, 1'b0);
				check_value("out_flit.payload", out_flit.payload, exp_head[`FLIT_WIDTH-1:0]);
				responses_seen <= responses_seen + 1;
				in_body = 1'b0;
			end
			else if (out_valid)
			begin
				if (exp_q.size() == 0)
					abort_run("response sent with no request outstanding");
				exp_head = exp_q[0];
				check_value("out_flit.head", out_flit.head, 1'b1);
				check_value("out_flit.payload", out_flit.payload,
					exp_head[2*`FLIT_WIDTH-1:`FLIT_WIDTH]);
				heads_seen <= heads_seen + 1;
				in_body = 1'b1;
			end
		end
	end

	// Network side returns one packet credit per response after a short random delay
	initial
	begin
		int delay;
		forever
		begin
			@(posedge clk);
			if (!reset && !hold_credits && heads_seen > credits_returned)
			begin
				delay = int'(random_bits(delay_state, 2));
				repeat (delay) @(posedge clk);
				out_credit_in <= 1'b1;
				credits_returned++;
				@(posedge clk);
				out_credit_in <= 1'b0;
			end
		end
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES)
			abort_run($sformatf("timeout after %0d cycles, packet %0d of %0d still outstanding",
				cycle_count, responses_seen + 1, packets_sent));
	end

	initial
	begin
		int base;
		reset         = 1'b1;
		in_valid      = 1'b0;
		in_flit       = '0;
		out_credit_in = 1'b0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		// Quiet after reset
		repeat (10)
		begin
			@(posedge clk);
			check_value("out_valid", out_valid, 1'b0);
			check_value("in_credit", in_credit, 1'b0);
		end

		// One directed packet per opcode
		send_packet(OP_SUM, 8'h10, directed_data(OP_SUM));
		send_packet(OP_XOR, 8'h11, directed_data(OP_XOR));
		send_packet(OP_MAX, 8'h12, directed_data(OP_MAX));
		send_packet(OP_MIN, 8'h13, directed_data(OP_MIN));
		wait_drain();

		// Random traffic at full rate
		repeat (RANDOM_PACKETS)
			send_random_packet();
		wait_drain();

		// Network withholds credits so one packet stays parked in the input buffer
		hold_credits = 1'b1;
		base = responses_seen;
		repeat (`OUTPUT_CREDITS + 1)
			send_random_packet();
		while (responses_seen < base + `OUTPUT_CREDITS)
			@(posedge clk);
		repeat (HOLD_CYCLES)
		begin
			@(posedge clk);
			check_value("out_valid", out_valid, 1'b0);
		end
		hold_credits = 1'b0;
		wait_drain();

		$display("No errors");
		$finish;
	end

endmodule

// File: all.f
+incdir+hdl
hdl/noc_flit_pkg.sv
hdl/test_engine_pkg.sv
hdl/nic_input_control_unit.sv
hdl/nic_input_block.sv
hdl/test_engine_pe.sv
hdl/nic_output_block.sv
hdl/test_engine_node.sv
tests/test_engine_node_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the test_engine_node testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f \
	--top-module test_engine_node_tb -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# Pass only if the testbench printed its pass line
if grep -qx "No errors" sim.log; then
	exit 0
fi
exit 1
